//--- serial_link_pkg.sv
/*
  Shared types for the serial link. Frame layout is fixed by FlitDataWidth,
  so the flit and frame structs only change if that width changes.
*/
package serial_link_pkg;

  // Flit payload width, the packed types below depend on it
  localparam int FlitDataWidth = 32;

  ////////////////////
  // Defaults
  ////////////////////

  localparam int DefNumLanes    = 4;
  localparam int DefLinkCredits = 4;
  localparam int DefNocCredits  = 2;

  ////////////////////
  // NoC side
  ////////////////////

  typedef struct packed {
    logic                     valid;
    logic                     hdr;
    logic [FlitDataWidth-1:0] data;
  } flit_t;

  ////////////////////
  // Link frames
  ////////////////////

  typedef enum logic {
    FRAME_FLIT   = 1'b0,
    FRAME_CREDIT = 1'b1
  } frame_kind_e;

  typedef struct packed {
    frame_kind_e              kind;
    logic                     hdr;
    logic [FlitDataWidth-1:0] data;
  } frame_t;

  localparam int FrameBits = $bits(frame_t);

  ////////////////////
  // Configuration
  ////////////////////

  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_CREDITS  = 2'd1,
    REG_TX_COUNT = 2'd2,
    REG_RX_COUNT = 2'd3
  } cfg_addr_e;

  typedef struct packed {
    logic        valid;
    logic        write;
    cfg_addr_e   addr;
    logic [31:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } cfg_rsp_t;

  typedef enum logic {
    LINK_OFF = 1'b0,
    LINK_ON  = 1'b1
  } link_state_e;

endpackage

//--- serial_link_ctrl.sv
/*
  Configuration registers and link credit bookkeeping.
  Every request gets a response one cycle later, writes to status registers are dropped.
*/
`timescale 1ns/1ps

module serial_link_ctrl import serial_link_pkg::*; #(
  parameter int LinkCredits = DefLinkCredits
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  cfg_req_t cfg_req_i,
  output cfg_rsp_t cfg_rsp_o,
  input  logic     flit_sent_i,
  input  logic     credit_received_i,
  input  logic     rx_flit_valid_i,
  output logic     send_ok_o
);

  localparam int CreditW = $clog2(LinkCredits + 1);

  link_state_e        link_state_q;
  logic [CreditW-1:0] credit_q;
  logic [31:0]        tx_count_q;
  logic [31:0]        rx_count_q;
  logic               rsp_valid_q;
  logic [31:0]        rsp_rdata_q;
  logic [31:0]        rdata_d;
  logic               ctrl_write;

  assign ctrl_write = cfg_req_i.valid && cfg_req_i.write && (cfg_req_i.addr == REG_CTRL);

  // Flits may only leave while the far buffer has room
  assign send_ok_o = (link_state_q == LINK_ON) && (credit_q != '0);

  ////////////////////
  // Link state
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      link_state_q <= LINK_OFF;
    end else if (ctrl_write) begin
      link_state_q <= cfg_req_i.wdata[0] ? LINK_ON : LINK_OFF;
    end
  end

  // Both events in one cycle cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= CreditW'(LinkCredits);
    end else begin
      case ({flit_sent_i, credit_received_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  ////////////////////
  // Flit counters
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_count_q <= '0;
      rx_count_q <= '0;
    end else begin
      if (flit_sent_i) begin
        tx_count_q <= tx_count_q + 32'd1;
      end
      if (rx_flit_valid_i) begin
        rx_count_q <= rx_count_q + 32'd1;
      end
    end
  end

  ////////////////////
  // Register read
  ////////////////////

  always_comb begin
    unique case (cfg_req_i.addr)
      REG_CTRL:     rdata_d = {31'd0, link_state_q == LINK_ON};
      REG_CREDITS:  rdata_d = 32'(credit_q);
      REG_TX_COUNT: rdata_d = tx_count_q;
      REG_RX_COUNT: rdata_d = rx_count_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.valid;
    end
  end

  // Read data is only sampled together with valid
  always_ff @(posedge clk_i) begin
    if (cfg_req_i.valid) begin
      rsp_rdata_q <= rdata_d;
    end
  end

  always_comb begin
    cfg_rsp_o.valid = rsp_valid_q;
    cfg_rsp_o.rdata = rsp_rdata_q;
  end

endmodule

//--- serial_link_noc_bridge.sv
/*
  NoC side buffers. The NoC sender must respect its NocCredits, the far link
  end must respect LinkCredits; neither FIFO checks for overflow.
*/
`timescale 1ns/1ps

module serial_link_noc_bridge import serial_link_pkg::*; #(
  parameter int LinkCredits = DefLinkCredits,
  parameter int NocCredits  = DefNocCredits
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  flit_t floo_in_i,
  output logic  floo_in_credit_o,
  output flit_t floo_out_o,
  input  logic  floo_out_credit_i,
  output flit_t tx_flit_o,
  input  logic  tx_take_i,
  input  flit_t rx_flit_i,
  output logic  rx_drained_o
);

  localparam int OutCreditW = $clog2(NocCredits + 1);

  // Index 0 is the input FIFO, index 1 the receive FIFO
  flit_t [1:0]           fifo_in;
  flit_t [1:0]           fifo_head;
  logic  [1:0]           fifo_pop;
  logic                  in_pop;
  logic                  out_pop;
  logic                  floo_in_credit_q;
  logic [OutCreditW-1:0] out_credit_q;

  assign fifo_in[0] = floo_in_i;
  assign fifo_in[1] = rx_flit_i;

  assign in_pop  = tx_take_i && fifo_head[0].valid;
  assign out_pop = fifo_head[1].valid && (out_credit_q != '0);

  assign fifo_pop[0] = in_pop;
  assign fifo_pop[1] = out_pop;

  for (genvar g = 0; g < 2; g++) begin : gen_fifo
    localparam int Depth = (g == 0) ? NocCredits : LinkCredits;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    flit_t           mem_q [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            push;
    flit_t           head;

    assign push = fifo_in[g].valid;

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= fifo_in[g];
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (fifo_pop[g]) begin
          rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !fifo_pop[g]) begin
          count_q <= count_q + 1'b1;
        end else if (fifo_pop[g] && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    // Head is valid only while the FIFO holds a flit
    always_comb begin
      head       = mem_q[rd_ptr_q];
      head.valid = (count_q != '0);
    end

    assign fifo_head[g] = head;
  end

  ////////////////////
  // Credit exchange
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      floo_in_credit_q <= 1'b0;
    end else begin
      floo_in_credit_q <= in_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_credit_q <= OutCreditW'(NocCredits);
    end else if (out_pop && !floo_out_credit_i) begin
      out_credit_q <= out_credit_q - 1'b1;
    end else if (floo_out_credit_i && !out_pop) begin
      out_credit_q <= out_credit_q + 1'b1;
    end
  end

  assign floo_in_credit_o = floo_in_credit_q;
  assign tx_flit_o        = fifo_head[0];
  assign rx_drained_o     = out_pop;

  always_comb begin
    floo_out_o       = fifo_head[1];
    floo_out_o.valid = out_pop;
  end

endmodule

//--- serial_link_data_link.sv
/*
  Frame builder and decoder. Owed credit returns are counted in 8 bits,
  so the link credit depth must stay below 256.
*/
`timescale 1ns/1ps

module serial_link_data_link import serial_link_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  flit_t  tx_flit_i,
  output logic   tx_take_o,
  input  logic   send_ok_i,
  input  logic   rx_drained_i,
  output flit_t  rx_flit_o,
  output logic   flit_sent_o,
  output logic   credit_received_o,
  output frame_t tx_frame_o,
  output logic   tx_frame_valid_o,
  input  logic   tx_busy_i,
  input  frame_t rx_frame_i,
  input  logic   rx_frame_valid_i
);

  localparam int OwedW = 8;

  logic [OwedW-1:0] owed_q;
  logic             send_credit;
  logic             send_flit;
  logic             frame_take;
  logic             credit_take;

  ////////////////////
  // Transmit
  ////////////////////

  // Credit returns win over flits so the far end never stalls on us
  assign send_credit = (owed_q != '0);
  assign send_flit   = !send_credit && tx_flit_i.valid && send_ok_i;

  always_comb begin
    tx_frame_o.kind = send_credit ? FRAME_CREDIT : FRAME_FLIT;
    tx_frame_o.hdr  = send_credit ? 1'b0 : tx_flit_i.hdr;
    tx_frame_o.data = send_credit ? '0 : tx_flit_i.data;
  end

  assign tx_frame_valid_o = send_credit || send_flit;

  // Phy takes the frame on the first free cycle
  assign frame_take  = tx_frame_valid_o && !tx_busy_i;
  assign credit_take = frame_take && send_credit;

  assign tx_take_o   = frame_take && send_flit;
  assign flit_sent_o = frame_take && send_flit;

  // One owed credit per drained receive buffer slot
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owed_q <= '0;
    end else begin
      case ({rx_drained_i, credit_take})
        2'b10:   owed_q <= owed_q + 1'b1;
        2'b01:   owed_q <= owed_q - 1'b1;
        default: owed_q <= owed_q;
      endcase
    end
  end

  ////////////////////
  // Receive
  ////////////////////

  always_comb begin
    rx_flit_o.valid = rx_frame_valid_i && (rx_frame_i.kind == FRAME_FLIT);
    rx_flit_o.hdr   = rx_frame_i.hdr;
    rx_flit_o.data  = rx_frame_i.data;
  end

  // Credit frames carry no payload, each returns one link credit
  assign credit_received_o = rx_frame_valid_i && (rx_frame_i.kind == FRAME_CREDIT);

endmodule

//--- serial_link_phy.sv
/*
  Lane serializer and deserializer, one bit per lane per clock, lower bits first.
  A frame takes FrameBeats cycles and frames are separated by at least one idle cycle.
*/
`timescale 1ns/1ps

module serial_link_phy import serial_link_pkg::*; #(
  parameter int NumLanes = DefNumLanes
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  frame_t              tx_frame_i,
  input  logic                tx_frame_valid_i,
  output logic                tx_busy_o,
  output frame_t              rx_frame_o,
  output logic                rx_frame_valid_o,
  output logic [NumLanes-1:0] ddr_o,
  output logic                ddr_valid_o,
  input  logic [NumLanes-1:0] ddr_i,
  input  logic                ddr_valid_i
);

  localparam int FrameBeats = (FrameBits + NumLanes - 1) / NumLanes;
  localparam int ShiftW     = FrameBeats * NumLanes;
  localparam int BeatW      = (FrameBeats > 1) ? $clog2(FrameBeats) : 1;

  logic [ShiftW-1:0]          tx_shift_q;
  logic [BeatW-1:0]           tx_beat_q;
  logic                       tx_busy_q;
  logic                       tx_take;
  logic [ShiftW-1:0]          rx_shift_q;
  logic [ShiftW+NumLanes-1:0] rx_shift_in;
  logic [BeatW-1:0]           rx_beat_q;
  logic                       rx_valid_q;

  ////////////////////
  // Serializer
  ////////////////////

  assign tx_take = tx_frame_valid_i && !tx_busy_q;

  always_ff @(posedge clk_i) begin
    if (tx_take) begin
      tx_shift_q <= ShiftW'(tx_frame_i);
    end else if (tx_busy_q) begin
      tx_shift_q <= tx_shift_q >> NumLanes;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_beat_q <= '0;
    end else if (tx_take) begin
      tx_busy_q <= 1'b1;
      tx_beat_q <= '0;
    end else if (tx_busy_q) begin
      // Drop busy after the last beat has been driven
      if (tx_beat_q == BeatW'(FrameBeats - 1)) begin
        tx_busy_q <= 1'b0;
      end
      tx_beat_q <= tx_beat_q + 1'b1;
    end
  end

  assign tx_busy_o   = tx_busy_q;
  assign ddr_valid_o = tx_busy_q;
  assign ddr_o       = tx_busy_q ? tx_shift_q[NumLanes-1:0] : '0;

  ////////////////////
  // Deserializer
  ////////////////////

  // New beats enter at the top and move down toward bit 0
  assign rx_shift_in = {ddr_i, rx_shift_q};

  always_ff @(posedge clk_i) begin
    if (ddr_valid_i) begin
      rx_shift_q <= rx_shift_in[ShiftW+NumLanes-1:NumLanes];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_beat_q  <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= 1'b0;
      if (ddr_valid_i) begin
        if (rx_beat_q == BeatW'(FrameBeats - 1)) begin
          rx_beat_q  <= '0;
          rx_valid_q <= 1'b1;
        end else begin
          rx_beat_q <= rx_beat_q + 1'b1;
        end
      end
    end
  end

  assign rx_frame_o       = frame_t'(rx_shift_q[FrameBits-1:0]);
  assign rx_frame_valid_o = rx_valid_q;

endmodule

//--- serial_link_top.sv
/*
  Single channel serial link, one clock domain, one bit per lane per clock.
  Lanes have no back-pressure, link credits must match the far receive buffer.
*/
`timescale 1ns/1ps

module serial_link_top import serial_link_pkg::*; #(
  parameter int NumLanes    = DefNumLanes,
  parameter int LinkCredits = DefLinkCredits,
  parameter int NocCredits  = DefNocCredits
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  flit_t               floo_in_i,
  output logic                floo_in_credit_o,
  output flit_t               floo_out_o,
  input  logic                floo_out_credit_i,
  input  cfg_req_t            cfg_req_i,
  output cfg_rsp_t            cfg_rsp_o,
  output logic [NumLanes-1:0] ddr_o,
  output logic                ddr_valid_o,
  input  logic [NumLanes-1:0] ddr_i,
  input  logic                ddr_valid_i
);

  flit_t  tx_flit;
  flit_t  rx_flit;
  logic   tx_take;
  logic   rx_drained;
  logic   send_ok;
  logic   flit_sent;
  logic   credit_received;
  frame_t tx_frame;
  logic   tx_frame_valid;
  logic   tx_busy;
  frame_t rx_frame;
  logic   rx_frame_valid;

  ////////////////////
  // Link controller
  ////////////////////

  serial_link_ctrl #(
    .LinkCredits ( LinkCredits )
  ) i_ctrl (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .cfg_req_i         ( cfg_req_i       ),
    .cfg_rsp_o         ( cfg_rsp_o       ),
    .flit_sent_i       ( flit_sent       ),
    .credit_received_i ( credit_received ),
    .rx_flit_valid_i   ( rx_flit.valid   ),
    .send_ok_o         ( send_ok         )
  );

  ////////////////////
  // Datapath
  ////////////////////

  serial_link_noc_bridge #(
    .LinkCredits ( LinkCredits ),
    .NocCredits  ( NocCredits  )
  ) i_noc_bridge (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .floo_in_i         ( floo_in_i         ),
    .floo_in_credit_o  ( floo_in_credit_o  ),
    .floo_out_o        ( floo_out_o        ),
    .floo_out_credit_i ( floo_out_credit_i ),
    .tx_flit_o         ( tx_flit           ),
    .tx_take_i         ( tx_take           ),
    .rx_flit_i         ( rx_flit           ),
    .rx_drained_o      ( rx_drained        )
  );

  serial_link_data_link i_data_link (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .tx_flit_i         ( tx_flit         ),
    .tx_take_o         ( tx_take         ),
    .send_ok_i         ( send_ok         ),
    .rx_drained_i      ( rx_drained      ),
    .rx_flit_o         ( rx_flit         ),
    .flit_sent_o       ( flit_sent       ),
    .credit_received_o ( credit_received ),
    .tx_frame_o        ( tx_frame        ),
    .tx_frame_valid_o  ( tx_frame_valid  ),
    .tx_busy_i         ( tx_busy         ),
    .rx_frame_i        ( rx_frame        ),
    .rx_frame_valid_i  ( rx_frame_valid  )
  );

  serial_link_phy #(
    .NumLanes ( NumLanes )
  ) i_phy (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .tx_frame_i       ( tx_frame       ),
    .tx_frame_valid_i ( tx_frame_valid ),
    .tx_busy_o        ( tx_busy        ),
    .rx_frame_o       ( rx_frame       ),
    .rx_frame_valid_o ( rx_frame_valid ),
    .ddr_o            ( ddr_o          ),
    .ddr_valid_o      ( ddr_valid_o    ),
    .ddr_i            ( ddr_i          ),
    .ddr_valid_i      ( ddr_valid_i    )
  );

endmodule

//--- serial_link_checker.sv
/*
  Assertions bound into serial_link_top. The link credit check reaches into
  the controller, so credit_q must keep its name there.
*/
`timescale 1ns/1ps

module serial_link_checker import serial_link_pkg::*; #(
  parameter int NumLanes    = DefNumLanes,
  parameter int LinkCredits = DefLinkCredits,
  parameter int NocCredits  = DefNocCredits
) (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic [$clog2(LinkCredits + 1)-1:0] link_credit_i,
  input logic                               out_valid_i,
  input logic                               out_credit_i,
  input logic                               ddr_valid_i
);

  localparam int FrameBeats = (FrameBits + NumLanes - 1) / NumLanes;

  // Output credits held by the link, rebuilt from the NoC port handshake
  int out_held_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_held_q <= NocCredits;
    end else begin
      out_held_q <= out_held_q - int'(out_valid_i) + int'(out_credit_i);
    end
  end

  // Credit frames can never return more than was handed out
  link_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_credit_i <= LinkCredits)
    else $error("link credit counter above %0d", LinkCredits);

  out_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> (out_held_q > 0))
    else $error("flit on floo_out_o without an output credit");

  // Each frame is one contiguous run of beats
  beat_run_length: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ddr_valid_i) |-> ddr_valid_i [*FrameBeats] ##1 !ddr_valid_i)
    else $error("ddr_valid_o run differs from %0d beats", FrameBeats);

endmodule

bind serial_link_top serial_link_checker #(
  .NumLanes    ( NumLanes    ),
  .LinkCredits ( LinkCredits ),
  .NocCredits  ( NocCredits  )
) i_checker (
  .clk_i         ( clk_i             ),
  .rst_n_i       ( rst_n_i           ),
  .link_credit_i ( i_ctrl.credit_q   ),
  .out_valid_i   ( floo_out_o.valid  ),
  .out_credit_i  ( floo_out_credit_i ),
  .ddr_valid_i   ( ddr_valid_o       )
);

//--- tb_serial_link.sv
/*
  Directed testbench with the lanes looped back onto themselves, so every
  flit sent in must come out again and every credit frame returns to us.
*/
`timescale 1ns/1ps

module tb_serial_link import serial_link_pkg::*; ();

  localparam int NumLanes    = DefNumLanes;
  localparam int LinkCredits = DefLinkCredits;
  localparam int NocCredits  = DefNocCredits;
  localparam int FrameBeats  = (FrameBits + NumLanes - 1) / NumLanes;
  // Tests need roughly 1000 cycles, 22 flits at about 25 cycles plus idle time
  localparam int MaxCycles   = 4000;

  logic                clk;
  logic                rst_n;
  flit_t               floo_in;
  logic                floo_in_credit;
  flit_t               floo_out;
  logic                floo_out_credit;
  cfg_req_t            cfg_req;
  cfg_rsp_t            cfg_rsp;
  logic [NumLanes-1:0] ddr;
  logic                ddr_valid;

  flit_t exp_q[$];
  int    in_credits;
  int    in_pulses;
  int    out_owed;
  int    return_gap;
  int    gap_cnt;
  int    rx_seen;
  int    total_sent;
  int    cycles;
  int    errors;
  int    checks;
  int    tests;

  serial_link_top #(
    .NumLanes    ( NumLanes    ),
    .LinkCredits ( LinkCredits ),
    .NocCredits  ( NocCredits  )
  ) dut (
    .clk_i             ( clk             ),
    .rst_n_i           ( rst_n           ),
    .floo_in_i         ( floo_in         ),
    .floo_in_credit_o  ( floo_in_credit  ),
    .floo_out_o        ( floo_out        ),
    .floo_out_credit_i ( floo_out_credit ),
    .cfg_req_i         ( cfg_req         ),
    .cfg_rsp_o         ( cfg_rsp         ),
    .ddr_o             ( ddr             ),
    .ddr_valid_o       ( ddr_valid       ),
    .ddr_i             ( ddr             ),
    .ddr_valid_i       ( ddr_valid       )
  );

  always #50 clk = ~clk;

  ////////////////////
  // Monitors
  ////////////////////

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    flit_t exp_flit;
    if (rst_n) begin
      if (floo_in_credit) begin
        in_credits++;
        in_pulses++;
      end
      if (floo_out.valid) begin
        rx_seen++;
        out_owed++;
        if (exp_q.size() == 0) begin
          $display("%0t: flit on floo_out_o while none was outstanding", $time);
          errors++;
        end else begin
          exp_flit = exp_q.pop_front();
          compare_word("floo_out_o.hdr", 32'(floo_out.hdr), 32'(exp_flit.hdr));
          compare_word("floo_out_o.data", floo_out.data, exp_flit.data);
        end
      end
    end
  end

  // Output credits go back one per return_gap + 1 cycles
  always @(negedge clk) begin
    if (out_owed > 0 && gap_cnt >= return_gap) begin
      floo_out_credit = 1'b1;
      out_owed--;
      gap_cnt = 0;
    end else begin
      floo_out_credit = 1'b0;
      gap_cnt++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Drivers
  ////////////////////

  // The response is due exactly one cycle after the request
  task automatic cfg_access(input logic write, input cfg_addr_e addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    cfg_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
    @(negedge clk);
    cfg_req = '0;
    checks++;
    if (cfg_rsp.valid !== 1'b1) begin
      $display("%0t: no cfg_rsp_o one cycle after the request", $time);
      errors++;
    end
    rdata = cfg_rsp.rdata;
  endtask

  task automatic send_flit(input logic hdr, input logic [31:0] data);
    @(negedge clk);
    while (in_credits == 0) begin
      @(negedge clk);
    end
    floo_in = '{valid: 1'b1, hdr: hdr, data: data};
    exp_q.push_back(floo_in);
    in_credits--;
    total_sent++;
    @(negedge clk);
    floo_in = '0;
  endtask

  task automatic wait_flits(input int n);
    while (rx_seen < n) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("test %-14s %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    int          err0;
    logic [31:0] rdata;
    err0 = errors;
    @(negedge clk);
    compare_word("floo_out_o.valid", 32'(floo_out.valid), 32'd0);
    compare_word("ddr_valid_o", 32'(ddr_valid), 32'd0);
    cfg_access(1'b0, REG_CREDITS, '0, rdata);
    compare_word("REG_CREDITS", rdata, 32'(LinkCredits));
    cfg_access(1'b0, REG_TX_COUNT, '0, rdata);
    compare_word("REG_TX_COUNT", rdata, 32'd0);
    cfg_access(1'b0, REG_RX_COUNT, '0, rdata);
    compare_word("REG_RX_COUNT", rdata, 32'd0);
    report_test("reset_state", err0);
  endtask

  task automatic test_link_enable();
    int          err0;
    int          beats;
    logic [31:0] rdata;
    err0  = errors;
    beats = 0;
    send_flit(1'($urandom), $urandom);
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      if (ddr_valid) begin
        beats++;
      end
    end
    checks++;
    if (beats != 0) begin
      $display("%0t: link sent %0d beats while disabled", $time, beats);
      errors++;
    end
    cfg_access(1'b1, REG_CTRL, 32'd1, rdata);
    cfg_access(1'b0, REG_CTRL, '0, rdata);
    compare_word("REG_CTRL", rdata, 32'd1);
    wait_flits(1);
    report_test("link_enable", err0);
  endtask

  task automatic test_single_flit();
    int err0;
    int base;
    int pulses0;
    err0    = errors;
    base    = rx_seen;
    pulses0 = in_pulses;
    send_flit(1'($urandom), $urandom);
    wait_flits(base + 1);
    compare_word("floo_in_credit_o pulses", 32'(in_pulses - pulses0), 32'd1);
    report_test("single_flit", err0);
  endtask

  task automatic test_burst();
    int err0;
    int base;
    int pulses0;
    err0       = errors;
    base       = rx_seen;
    pulses0    = in_pulses;
    // Slower than the link, so the receive buffer fills up
    return_gap = 24;
    for (int i = 0; i < 20; i++) begin
      send_flit(1'($urandom), $urandom);
    end
    wait_flits(base + 20);
    return_gap = 0;
    compare_word("floo_in_credit_o pulses", 32'(in_pulses - pulses0), 32'd20);
    report_test("burst", err0);
  endtask

  task automatic test_counters();
    int          err0;
    int          quiet;
    logic [31:0] rdata;
    err0  = errors;
    quiet = 0;
    // Wait out the trailing credit frames
    while (quiet < 2 * FrameBeats + 4) begin
      @(negedge clk);
      quiet = ddr_valid ? 0 : quiet + 1;
    end
    cfg_access(1'b0, REG_TX_COUNT, '0, rdata);
    compare_word("REG_TX_COUNT", rdata, 32'(total_sent));
    cfg_access(1'b0, REG_RX_COUNT, '0, rdata);
    compare_word("REG_RX_COUNT", rdata, 32'(total_sent));
    cfg_access(1'b0, REG_CREDITS, '0, rdata);
    compare_word("REG_CREDITS", rdata, 32'(LinkCredits));
    compare_word("outstanding flits", 32'(exp_q.size()), 32'd0);
    report_test("counters", err0);
  endtask

  initial begin
    void'($urandom(32'hd2cf_dacc));
    clk             = 1'b0;
    rst_n           = 1'b0;
    floo_in         = '0;
    floo_out_credit = 1'b0;
    cfg_req         = '0;
    in_credits      = NocCredits;
    in_pulses       = 0;
    out_owed        = 0;
    return_gap      = 0;
    gap_cnt         = 0;
    rx_seen         = 0;
    total_sent      = 0;
    cycles          = 0;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_link_enable();
    test_single_flit();
    test_burst();
    test_counters();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- serial_link.f
serial_link_pkg.sv
serial_link_ctrl.sv
serial_link_noc_bridge.sv
serial_link_data_link.sv
serial_link_phy.sv
serial_link_top.sv
serial_link_checker.sv
tb_serial_link.sv
